/* Makefile */
# Verilator build and run of the data-memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= memSubsysTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SRCS    := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early, see $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/memSubsysTb.sv */
// =========================================================================
// testbench for the data-memory subsystem
// directed tests against a shadow memory model with LCG data
// =========================================================================

module memSubsysTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TbMemWords = 256;
  localparam int IdxBits = $clog2(TbMemWords);
  // limit well above the roughly 600 cycles the tests take
  localparam int TimeoutCycles = 4000;
  localparam logic [31:0] GpioOutAddr = memMapPkg::GpioBase + memMapPkg::GpioOutOfs;
  localparam logic [31:0] GpioCountAddr = memMapPkg::GpioBase + memMapPkg::GpioCountOfs;

  logic          clk;
  logic          reset;
  busPkg::busReq req;
  busPkg::busRsp rsp;
  logic [31:0]   gpioOut;

  // shadow of the data memory
  logic [31:0] shadow [TbMemWords];
  logic [31:0] lcgState = 32'h53b2;
  int errorCount = 0;
  int checkCount = 0;
  int cycles = 0;

  memSubsys #(.MemWords(TbMemWords)) dut0 (
    .clk(clk), .reset(reset), .req(req), .rsp(rsp), .gpioOut(gpioOut)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("timeout, tests still running after %0d cycles", cycles);
      $display("Something failed");
      $finish;
    end
  end

  // numerical recipes constants
  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // expected word after a write
  // bytes outside the transfer keep the old value
  function automatic logic [31:0] expectMerge(logic [31:0] old, logic [31:0] data,
                                              busPkg::xferSize size, logic [1:0] ofs);
    logic [31:0] keep;
    case (size)
      busPkg::sizeWord: keep = 32'h0000_0000;
      busPkg::sizeHalf: keep = ofs[1] ? 32'h0000_ffff : 32'hffff_0000;
      busPkg::sizeByte: keep = ~(32'hff << (8 * ofs));
      default:          keep = 32'hffff_ffff;
    endcase
    return (old & keep) | (data & ~keep);
  endfunction

  task automatic checkEq(string name, logic [31:0] got, logic [31:0] exp);
    checkCount++;
    assert (got === exp) else begin
      errorCount++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic reportTest(string name, int errsBefore);
    $display("%s finished with %0d errors", name, errorCount - errsBefore);
  endtask

  // new request on the falling edge
  task automatic drive(logic [31:0] addr, logic [31:0] data, busPkg::xferSize size,
                       logic we, logic re);
    @(negedge clk);
    req = {addr, data, size, we, re};
  endtask

  task automatic idle(int n);
    repeat (n) drive(32'h0, 32'h0, busPkg::sizeWord, 1'b0, 1'b0);
  endtask

  // DUT commits at the next rising edge
  // model is updated right away
  task automatic writeBus(logic [31:0] addr, logic [31:0] data, busPkg::xferSize size,
                          logic expErr);
    drive(addr, data, size, 1'b1, 1'b0);
    #1;
    checkEq("rsp.valid", 32'(rsp.valid), 32'h1);
    checkEq("rsp.err", 32'(rsp.err), 32'(expErr));
    if (!expErr && addr[31:28] == memMapPkg::MemBase[31:28]) begin
      shadow[addr[IdxBits+1:2]] = expectMerge(shadow[addr[IdxBits+1:2]], data, size,
                                              addr[1:0]);
    end
  endtask

  // combinational read data sampled mid low phase
  task automatic readCheck(logic [31:0] addr, busPkg::xferSize size, logic [31:0] exp,
                           logic expErr);
    drive(addr, 32'h0, size, 1'b0, 1'b1);
    #1;
    checkEq("rsp.valid", 32'(rsp.valid), 32'h1);
    checkEq("rsp.err", 32'(rsp.err), 32'(expErr));
    checkEq("rsp.rdata", rsp.rdata, exp);
  endtask

  task automatic readWord(logic [31:0] addr, output logic [31:0] value);
    drive(addr, 32'h0, busPkg::sizeWord, 1'b0, 1'b1);
    #1;
    checkEq("rsp.err", 32'(rsp.err), 32'h0);
    value = rsp.rdata;
  endtask

  task automatic wordAccessTest();
    int errs;
    logic [31:0] addr;
    errs = errorCount;
    // spread over the array
    for (int i = 0; i < 8; i++) begin
      writeBus(32'((i * 37) % TbMemWords * 4), nextRand(), busPkg::sizeWord, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      addr = 32'((i * 37) % TbMemWords * 4);
      readCheck(addr, busPkg::sizeWord, shadow[addr[IdxBits+1:2]], 1'b0);
    end
    reportTest("word access", errs);
  endtask

  task automatic laneWriteTest();
    int errs;
    logic [31:0] addr;
    errs = errorCount;
    addr = 32'h0000_0028;
    writeBus(addr, 32'h1122_3344, busPkg::sizeWord, 1'b0);
    for (int ofs = 0; ofs < 4; ofs++) begin
      writeBus(addr + 32'(ofs), nextRand(), busPkg::sizeByte, 1'b0);
      readCheck(addr + 32'(ofs), busPkg::sizeByte, shadow[addr[IdxBits+1:2]], 1'b0);
    end
    // lower then upper halfword
    for (int ofs = 0; ofs < 4; ofs += 2) begin
      writeBus(addr + 32'(ofs), nextRand(), busPkg::sizeHalf, 1'b0);
      readCheck(addr + 32'(ofs), busPkg::sizeHalf, shadow[addr[IdxBits+1:2]], 1'b0);
    end
    reportTest("byte and halfword writes", errs);
  endtask

  task automatic outputRegTest();
    int errs;
    logic [31:0] expOut;
    logic [31:0] data;
    errs = errorCount;
    expOut = 32'h0;
    checkEq("gpioOut", gpioOut, expOut);
    readCheck(GpioOutAddr, busPkg::sizeWord, expOut, 1'b0);
    for (int ofs = 0; ofs < 4; ofs++) begin
      data = nextRand();
      writeBus(GpioOutAddr + 32'(ofs), data, busPkg::sizeByte, 1'b0);
      // write edge not reached yet
      checkEq("gpioOut", gpioOut, expOut);
      expOut = expectMerge(expOut, data, busPkg::sizeByte, 2'(ofs));
      idle(1);
      #1;
      checkEq("gpioOut", gpioOut, expOut);
    end
    readCheck(GpioOutAddr, busPkg::sizeWord, expOut, 1'b0);
    reportTest("output register", errs);
  endtask

  task automatic counterTest();
    int errs;
    int n;
    logic [31:0] c0;
    logic [31:0] c1;
    errs = errorCount;
    for (int k = 0; k < 2; k++) begin
      n = 3 + int'(nextRand() & 32'h7);
      readWord(GpioCountAddr, c0);
      // two edges since the last read, one of them the refused write
      // an accepted write would break the count here
      if (k == 1) begin
        checkEq("count after write", c0 - c1, 32'd2);
      end
      // second read lands n falling edges later
      idle(n - 1);
      readWord(GpioCountAddr, c1);
      checkEq("count delta", c1 - c0, 32'(n));
      // counter is read-only so the write is refused
      if (k == 0) begin
        writeBus(GpioCountAddr, nextRand(), busPkg::sizeWord, 1'b1);
      end
    end
    reportTest("cycle counter", errs);
  endtask

  task automatic errorTest();
    int errs;
    logic [31:0] outBefore;
    errs = errorCount;
    writeBus(32'h0000_0000, nextRand(), busPkg::sizeWord, 1'b0);
    writeBus(32'h0000_0014, nextRand(), busPkg::sizeWord, 1'b0);
    // region 2 maps nothing
    writeBus(32'h2000_0014, nextRand(), busPkg::sizeWord, 1'b1);
    readCheck(32'h2000_0014, busPkg::sizeWord, 32'h0, 1'b1);
    // just past the memory where index bits alias word 0
    writeBus(32'(TbMemWords * 4), nextRand(), busPkg::sizeWord, 1'b1);
    readCheck(32'(TbMemWords * 4), busPkg::sizeWord, 32'h0, 1'b1);
    outBefore = gpioOut;
    writeBus(memMapPkg::GpioBase + 32'h8, nextRand(), busPkg::sizeWord, 1'b1);
    readCheck(memMapPkg::GpioBase + 32'h8, busPkg::sizeWord, 32'h0, 1'b1);
    checkEq("gpioOut", gpioOut, outBefore);
    // unused size code still reads back the whole word
    writeBus(32'h0000_0014, nextRand(), busPkg::sizeBad, 1'b1);
    readCheck(32'h0000_0014, busPkg::sizeBad, shadow[5], 1'b1);
    readCheck(32'h0000_0000, busPkg::sizeWord, shadow[0], 1'b0);
    readCheck(32'h0000_0014, busPkg::sizeWord, shadow[5], 1'b0);
    reportTest("errors", errs);
  endtask

  task automatic randomTrafficTest();
    int errs;
    logic [31:0] r;
    logic [31:0] addr;
    busPkg::xferSize size;
    errs = errorCount;
    // every word defined before random reads
    for (int i = 0; i < TbMemWords; i++) begin
      writeBus(32'(i * 4), nextRand(), busPkg::sizeWord, 1'b0);
    end
    for (int i = 0; i < 200; i++) begin
      r = nextRand();
      // upper lcg bits since the low ones repeat quickly
      size = busPkg::xferSize'((r[17:16] == 2'b11) ? 2'b10 : r[17:16]);
      addr = 32'(r[31 -: IdxBits]) << 2;
      if (size == busPkg::sizeByte) begin
        addr[1:0] = r[15:14];
      end else if (size == busPkg::sizeHalf) begin
        addr[1] = r[15];
      end
      if (r[20]) begin
        writeBus(addr, nextRand(), size, 1'b0);
      end else begin
        readCheck(addr, size, shadow[addr[IdxBits+1:2]], 1'b0);
      end
    end
    reportTest("random traffic", errs);
  endtask

  initial begin
    req = '0;
    reset = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    wordAccessTest();
    laneWriteTest();
    outputRegTest();
    counterTest();
    errorTest();
    randomTrafficTest();
    idle(1);
    $display("%0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* dv/memSubsys_asserts.sv */
// =========================================================================
// bus protocol checks for the data-memory subsystem
// bound to every memSubsys instance
// =========================================================================

module memSubsysAsserts (
  input logic          clk,
  input logic          reset,
  input busPkg::busReq req,
  input busPkg::busRsp rsp,
  input logic [31:0]   gpioOut,
  input logic          memSel,
  input logic          gpioSel
);
  timeunit 1ns;
  timeprecision 100ps;

  // decoder picks one target at most
  oneTarget: assert property (@(posedge clk) !(memSel && gpioSel))
    else $error("memory and register block selected together");

  // valid is a plain level, no handshake
  validLevel: assert property (@(posedge clk) rsp.valid == (req.re | req.we))
    else $error("response valid differs from re or we");

  // first edge out of reset sees the cleared output register
  outAfterReset: assert property (@(posedge clk) ($past(reset) && !reset) |-> gpioOut == 32'h0)
    else $error("gpioOut not zero after reset");

endmodule

bind memSubsys memSubsysAsserts asserts0 (
  .clk(clk), .reset(reset), .req(req), .rsp(rsp),
  .gpioOut(gpioOut), .memSel(memSel), .gpioSel(gpioSel)
);

/* flist.f */
src/busPkg.sv
src/memMapPkg.sv
src/addrDecoder.sv
src/dataMem.sv
src/gpioRegs.sv
src/memSubsys.sv
dv/memSubsys_asserts.sv
dv/memSubsysTb.sv

/* src/addrDecoder.sv */
// =========================================================================
// address decoder
// picks memory or register block from the address, muxes read data
// and builds the response with the error flag
// =========================================================================

module addrDecoder #(
  parameter int MemWords = 1024
) (
  input  busPkg::busReq req,
  input  logic [31:0]   memRdata,
  input  logic [31:0]   gpioRdata,
  input  logic          memSizeErr,
  input  logic          gpioSizeErr,
  output logic          memSel,
  output logic          gpioSel,
  output busPkg::busRsp rsp
);

  localparam int OfsBits = 32 - memMapPkg::RegionBits;
  // end of the memory inside its region
  localparam logic [OfsBits-1:0] MemBytes = OfsBits'(MemWords * 4);

  logic [memMapPkg::RegionBits-1:0] region;
  logic [OfsBits-1:0]               regionOfs;
  logic                             memHit;
  logic                             gpioHit;
  logic                             targetErr;
  memMapPkg::targetSel              target;

  assign region    = req.addr[31 -: memMapPkg::RegionBits];
  assign regionOfs = req.addr[OfsBits-1:0];

  // memory region, but only up to the last word
  assign memHit = (region == memMapPkg::MemBase[31 -: memMapPkg::RegionBits]) &&
                  (regionOfs < MemBytes);

  // gpio region, word offsets of the two registers only
  assign gpioHit = (region == memMapPkg::GpioBase[31 -: memMapPkg::RegionBits]) &&
                   ((regionOfs[OfsBits-1:2] == memMapPkg::GpioOutOfs[OfsBits-1:2]) ||
                    (regionOfs[OfsBits-1:2] == memMapPkg::GpioCountOfs[OfsBits-1:2]));

  always_comb begin
    if (memHit) begin
      target = memMapPkg::tgtMem;
    end else if (gpioHit) begin
      target = memMapPkg::tgtGpio;
    end else begin
      target = memMapPkg::tgtNone;
    end
  end

  // one-hot by construction of target
  assign memSel  = (target == memMapPkg::tgtMem);
  assign gpioSel = (target == memMapPkg::tgtGpio);

  // response mux, unmapped reads give zero and always error
  always_comb begin
    rsp.valid = req.re | req.we;
    case (target)
      memMapPkg::tgtMem: begin
        rsp.rdata = memRdata;
        targetErr = memSizeErr;
      end
      memMapPkg::tgtGpio: begin
        rsp.rdata = gpioRdata;
        targetErr = gpioSizeErr;
      end
      default: begin
        rsp.rdata = 32'h0;
        targetErr = 1'b1;
      end
    endcase
    rsp.err = rsp.valid & targetErr;
  end

endmodule

/* src/busPkg.sv */
// =========================================================================
// bus types for the data-memory subsystem
// one-phase request and response structs, transfer sizes and lane masks
// =========================================================================

package busPkg;

  // transfer size, same coding as the low bits of HSIZE
  typedef enum logic [1:0] {
    sizeByte = 2'b00,
    sizeHalf = 2'b01,
    sizeWord = 2'b10,
    sizeBad  = 2'b11
  } xferSize;

  // request, address and data presented together with the levels
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    xferSize     size;
    logic        we;
    logic        re;
  } busReq;

  // response, read data is combinational
  typedef struct packed {
    logic [31:0] rdata;
    logic        valid;
    logic        err;
  } busRsp;

  // lane mask from size and low address bits
  // write data is already lane aligned, so no shifting of wdata
  function automatic logic [3:0] byteLanes(xferSize size, logic [1:0] lowAddr);
    logic [3:0] lanes;
    case (size)
      sizeByte: lanes = 4'b0001 << lowAddr;
      sizeHalf: lanes = lowAddr[1] ? 4'b1100 : 4'b0011;
      sizeWord: lanes = 4'b1111;
      default:  lanes = 4'b0000;
    endcase
    return lanes;
  endfunction

endpackage

/* src/dataMem.sv */
// =========================================================================
// byte-addressable data memory
// word array with lane-merged writes and a combinational read port
// =========================================================================

module dataMem #(
  parameter int MemWords = 1024
) (
  input  logic          clk,
  input  busPkg::busReq req,
  input  logic          sel,
  output logic [31:0]   rdata,
  output logic          sizeErr
);

  // word index width, MemWords is a power of two
  localparam int AddrBits = $clog2(MemWords);

  // storage, contents undefined until written
  logic [31:0] mem [MemWords];

  logic [AddrBits-1:0] wordIdx;
  logic [3:0]          lanes;
  logic                wrEn;

  // byte address bits 1:0 only pick lanes
  assign wordIdx = req.addr[AddrBits+1:2];

  // enabled lanes for this transfer
  // empty for the unused size code, so such a write is dropped
  assign lanes = busPkg::byteLanes(req.size, req.addr[1:0]);

  // write only when the decoder picked us
  assign wrEn = sel & req.we;

  // whole word comes back for any size
  assign rdata = mem[wordIdx];

  // size is the only thing checked here
  assign sizeErr = (req.size == busPkg::sizeBad);

  // lane merge
  // byte: one lane at addr[1:0]
  // halfword: lower or upper pair by addr[1]
  // word: all four lanes
  // untouched lanes keep the stored bytes
  always_ff @(posedge clk) begin
    if (wrEn) begin
      for (int i = 0; i < 4; i++) begin
        if (lanes[i]) begin
          mem[wordIdx][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

/* src/gpioRegs.sv */
// =========================================================================
// register block
// general-purpose output register and a free-running cycle counter
// =========================================================================

module gpioRegs (
  input  logic          clk,
  input  logic          reset,
  input  busPkg::busReq req,
  input  logic          sel,
  output logic [31:0]   rdata,
  output logic [31:0]   gpioOut,
  output logic          sizeErr
);

  logic [31:0] outReg;
  logic [31:0] cycleCount;
  logic [3:0]  lanes;
  logic        isCount;
  logic        outWrEn;

  // decoder only selects the two legal offsets, so bit 2 is enough
  assign isCount = (req.addr[3:2] == memMapPkg::GpioCountOfs[3:2]);

  assign lanes = busPkg::byteLanes(req.size, req.addr[1:0]);

  // counter is read-only, writes to it are dropped
  assign outWrEn = sel & req.we & ~isCount;

  // bad size or counter write
  assign sizeErr = (req.size == busPkg::sizeBad) | (req.we & isCount);

  // read mux by offset
  assign rdata = isCount ? cycleCount : outReg;

  // output pins come straight from the register
  assign gpioOut = outReg;

  // output register, per-lane update
  always_ff @(posedge clk) begin
    if (reset) begin
      outReg <= 32'h0;
    end else if (outWrEn) begin
      for (int i = 0; i < 4; i++) begin
        if (lanes[i]) begin
          outReg[8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

  // free-running, wraps at 2^32
  always_ff @(posedge clk) begin
    if (reset) begin
      cycleCount <= 32'h0;
    end else begin
      cycleCount <= cycleCount + 32'd1;
    end
  end

endmodule

/* src/memMapPkg.sv */
// =========================================================================
// address map of the data-memory subsystem
// region bases, region field width and register offsets
// =========================================================================

package memMapPkg;

  // decoded target of a transfer
  typedef enum logic [1:0] {
    tgtMem  = 2'd0,
    tgtGpio = 2'd1,
    tgtNone = 2'd2
  } targetSel;

  // region field is the top of the address
  parameter int RegionBits = 4;

  // region bases, only bits 31:28 are compared
  parameter logic [31:0] MemBase  = 32'h0000_0000;
  parameter logic [31:0] GpioBase = 32'h4000_0000;

  // word offsets inside the gpio region
  parameter logic [31:0] GpioOutOfs   = 32'h0000_0000;
  parameter logic [31:0] GpioCountOfs = 32'h0000_0004;

endpackage

/* src/memSubsys.sv */
// =========================================================================
// data-memory subsystem top
// decoder in front of the data memory and the register block
// =========================================================================

module memSubsys #(
  parameter int MemWords = 1024
) (
  input  logic          clk,
  input  logic          reset,
  input  busPkg::busReq req,
  output busPkg::busRsp rsp,
  output logic [31:0]   gpioOut
);

  logic        memSel;
  logic        gpioSel;
  logic [31:0] memRdata;
  logic [31:0] gpioRdata;
  logic        memSizeErr;
  logic        gpioSizeErr;

  // target select and response
  addrDecoder #(.MemWords(MemWords)) decoder (
    .req(req), .memRdata(memRdata), .gpioRdata(gpioRdata),
    .memSizeErr(memSizeErr), .gpioSizeErr(gpioSizeErr),
    .memSel(memSel), .gpioSel(gpioSel), .rsp(rsp)
  );

  // no reset on the array
  dataMem #(.MemWords(MemWords)) memory (
    .clk(clk), .req(req), .sel(memSel),
    .rdata(memRdata), .sizeErr(memSizeErr)
  );

  // output register and counter
  gpioRegs gpioBlock (
    .clk(clk), .reset(reset), .req(req), .sel(gpioSel),
    .rdata(gpioRdata), .gpioOut(gpioOut), .sizeErr(gpioSizeErr)
  );

endmodule
